// ==== cluster_periph_pkg.sv ====
package cluster_periph_pkg;

  // bus and register sizes
  localparam int DATA_W     = 32;
  localparam int REG_W      = 8;
  localparam int SLV_W      = 4;
  localparam int NB_EVENTS  = 8;
  localparam int NB_EXT_EVT = 4;

  // slave slots, anything else lands on the error responder
  localparam logic [SLV_W-1:0] SLV_CTRL  = 4'd0;
  localparam logic [SLV_W-1:0] SLV_TIMER = 4'd1;
  localparam logic [SLV_W-1:0] SLV_EVENT = 4'd2;

  // cluster control unit
  localparam logic [REG_W-1:0] CTRL_EOC       = 8'd0;
  localparam logic [REG_W-1:0] CTRL_FETCH_EN  = 8'd1;
  localparam logic [REG_W-1:0] CTRL_BOOT_BASE = 8'd16;

  // timer
  localparam logic [REG_W-1:0] TMR_CTRL  = 8'd0;
  localparam logic [REG_W-1:0] TMR_COUNT = 8'd1;
  localparam logic [REG_W-1:0] TMR_CMP   = 8'd2;

  // event unit, per-core block of EU_STRIDE registers
  localparam logic [REG_W-1:0] EU_MASK   = 8'd0;
  localparam logic [REG_W-1:0] EU_BUFFER = 8'd1;
  localparam logic [REG_W-1:0] EU_CLEAR  = 8'd2;
  localparam logic [REG_W-1:0] EU_STRIDE = 8'd4;

  localparam logic [DATA_W-1:0] ERR_RDATA = 32'hBADC_AB7E;

  typedef union packed {
    logic [DATA_W-1:0] raw;
    struct packed {
      logic [17:0]      tag;
      logic [SLV_W-1:0] slv;
      logic [REG_W-1:0] reg_idx;
      logic [1:0]       byte_off;
    } f;
  } periph_addr_t;

endpackage

// ==== periph_demux.sv ====
`timescale 1ns/1ps

module periph_demux #(
  parameter int ID_W = 5
) (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic                                  req_i,
  input  cluster_periph_pkg::periph_addr_t      add_i,
  input  logic                                  wen_i,
  input  logic [cluster_periph_pkg::DATA_W-1:0] wdata_i,
  input  logic [ID_W-1:0]                       id_i,
  output logic                                  gnt_o,
  output logic                                  r_valid_o,
  output logic                                  r_opc_o,
  output logic [cluster_periph_pkg::DATA_W-1:0] r_rdata_o,
  output logic [ID_W-1:0]                       r_id_o,
  output logic                                  ctrl_sel_o,
  output logic                                  ctrl_we_o,
  output logic [cluster_periph_pkg::REG_W-1:0]  ctrl_reg_o,
  output logic [cluster_periph_pkg::DATA_W-1:0] ctrl_wdata_o,
  input  logic [cluster_periph_pkg::DATA_W-1:0] ctrl_rdata_i,
  output logic                                  tmr_sel_o,
  output logic                                  tmr_we_o,
  output logic [cluster_periph_pkg::REG_W-1:0]  tmr_reg_o,
  output logic [cluster_periph_pkg::DATA_W-1:0] tmr_wdata_o,
  input  logic [cluster_periph_pkg::DATA_W-1:0] tmr_rdata_i,
  output logic                                  eu_sel_o,
  output logic                                  eu_we_o,
  output logic [cluster_periph_pkg::REG_W-1:0]  eu_reg_o,
  output logic [cluster_periph_pkg::DATA_W-1:0] eu_wdata_o,
  input  logic [cluster_periph_pkg::DATA_W-1:0] eu_rdata_i
);
  import cluster_periph_pkg::*;

  logic [SLV_W-1:0]  slv, slv_q;
  logic              unmapped;
  logic              valid_q, err_q, rd_q;
  logic [ID_W-1:0]   id_q;
  logic [DATA_W-1:0] unit_rdata;

  assign slv      = add_i.f.slv;
  assign unmapped = (slv != SLV_CTRL) && (slv != SLV_TIMER) && (slv != SLV_EVENT);

  // every slot grants at once
  assign gnt_o = req_i;

  assign ctrl_sel_o   = req_i && (slv == SLV_CTRL);
  assign tmr_sel_o    = req_i && (slv == SLV_TIMER);
  assign eu_sel_o     = req_i && (slv == SLV_EVENT);
  assign ctrl_we_o    = ~wen_i;
  assign tmr_we_o     = ~wen_i;
  assign eu_we_o      = ~wen_i;
  assign ctrl_reg_o   = add_i.f.reg_idx;
  assign tmr_reg_o    = add_i.f.reg_idx;
  assign eu_reg_o     = add_i.f.reg_idx;
  assign ctrl_wdata_o = wdata_i;
  assign tmr_wdata_o  = wdata_i;
  assign eu_wdata_o   = wdata_i;

  // response tag for the access granted this cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      err_q   <= 1'b0;
      rd_q    <= 1'b0;
      slv_q   <= '0;
      id_q    <= '0;
    end else begin
      valid_q <= req_i;
      err_q   <= req_i && unmapped;
      rd_q    <= req_i && wen_i;
      slv_q   <= slv;
      id_q    <= id_i;
    end
  end

  always_comb begin
    case (slv_q)
      SLV_CTRL:  unit_rdata = ctrl_rdata_i;
      SLV_TIMER: unit_rdata = tmr_rdata_i;
      SLV_EVENT: unit_rdata = eu_rdata_i;
      default:   unit_rdata = '0;
    endcase
  end

  // error responder answers reads and writes alike
  assign r_rdata_o = err_q ? ERR_RDATA : (rd_q ? unit_rdata : '0);
  assign r_opc_o   = err_q;
  assign r_valid_o = valid_q;
  assign r_id_o    = id_q;

endmodule

// ==== cluster_ctrl_unit.sv ====
`timescale 1ns/1ps

module cluster_ctrl_unit #(
  parameter int                                    NB_CORES  = 4,
  parameter logic [cluster_periph_pkg::DATA_W-1:0] BOOT_ADDR = 32'h1C00_0000
) (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic                                  sel_i,
  input  logic                                  we_i,
  input  logic [cluster_periph_pkg::REG_W-1:0]  reg_i,
  input  logic [cluster_periph_pkg::DATA_W-1:0] wdata_i,
  output logic [cluster_periph_pkg::DATA_W-1:0] rdata_o,
  output logic                                  eoc_o,
  output logic [NB_CORES-1:0]                   fetch_enable_o,
  output logic [NB_CORES-1:0][cluster_periph_pkg::DATA_W-1:0] boot_addr_o
);
  import cluster_periph_pkg::*;

  logic                           eoc_q;
  logic [NB_CORES-1:0]            fetch_en_q;
  logic [NB_CORES-1:0][DATA_W-1:0] boot_q;
  logic                           wr;
  logic [DATA_W-1:0]              rdata_d;

  assign wr = sel_i && we_i;

  // ********************
  // register writes
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      eoc_q      <= 1'b0;
      fetch_en_q <= '0;
      for (int c = 0; c < NB_CORES; c++) begin
        boot_q[c] <= BOOT_ADDR;
      end
    end else if (wr) begin
      if (reg_i == CTRL_EOC) begin
        eoc_q <= wdata_i[0];
      end
      if (reg_i == CTRL_FETCH_EN) begin
        fetch_en_q <= wdata_i[NB_CORES-1:0];
      end
      // one boot address per core
      for (int c = 0; c < NB_CORES; c++) begin
        if (reg_i == CTRL_BOOT_BASE + REG_W'(c)) begin
          boot_q[c] <= wdata_i;
        end
      end
    end
  end

  // ********************
  // read path, unknown indices give 0
  always_comb begin
    rdata_d = '0;
    if (reg_i == CTRL_EOC) begin
      rdata_d = DATA_W'(eoc_q);
    end
    if (reg_i == CTRL_FETCH_EN) begin
      rdata_d = DATA_W'(fetch_en_q);
    end
    for (int c = 0; c < NB_CORES; c++) begin
      if (reg_i == CTRL_BOOT_BASE + REG_W'(c)) begin
        rdata_d = boot_q[c];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_i && !we_i) begin
      rdata_o <= rdata_d;
    end
  end

  assign eoc_o          = eoc_q;
  assign fetch_enable_o = fetch_en_q;
  assign boot_addr_o    = boot_q;

endmodule

// ==== cluster_timer.sv ====
`timescale 1ns/1ps

module cluster_timer (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic                                  sel_i,
  input  logic                                  we_i,
  input  logic [cluster_periph_pkg::REG_W-1:0]  reg_i,
  input  logic [cluster_periph_pkg::DATA_W-1:0] wdata_i,
  output logic [cluster_periph_pkg::DATA_W-1:0] rdata_o,
  output logic                                  evt_o,
  output logic                                  busy_o
);
  import cluster_periph_pkg::*;

  // control word bits
  localparam int EN_BIT  = 0;
  localparam int CLR_BIT = 1;

  logic              en_q;
  logic [DATA_W-1:0] cnt_q;
  logic [DATA_W-1:0] cmp_q;
  logic              match;
  logic              wr;
  logic [DATA_W-1:0] rdata_d;

  assign wr    = sel_i && we_i;
  assign match = en_q && (cnt_q == cmp_q);

  // ********************
  // counter and registers
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      en_q  <= 1'b0;
      cnt_q <= '0;
      cmp_q <= '1;
    end else begin
      // wrap on compare, period is cmp + 1
      if (match) begin
        cnt_q <= '0;
      end else if (en_q) begin
        cnt_q <= cnt_q + 1'b1;
      end
      // bus writes take priority over counting
      if (wr) begin
        case (reg_i)
          TMR_CTRL: begin
            en_q <= wdata_i[EN_BIT];
            if (wdata_i[CLR_BIT]) begin
              cnt_q <= '0;
            end
          end
          TMR_COUNT: cnt_q <= wdata_i;
          TMR_CMP:   cmp_q <= wdata_i;
          default: ;
        endcase
      end
    end
  end

  // clear is a strobe and reads back 0
  always_comb begin
    case (reg_i)
      TMR_CTRL:  rdata_d = DATA_W'(en_q);
      TMR_COUNT: rdata_d = cnt_q;
      TMR_CMP:   rdata_d = cmp_q;
      default:   rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (sel_i && !we_i) begin
      rdata_o <= rdata_d;
    end
  end

  assign evt_o  = match;
  assign busy_o = en_q;

endmodule

// ==== event_unit.sv ====
`timescale 1ns/1ps

module event_unit #(
  parameter int NB_CORES = 4
) (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  input  logic                                      sel_i,
  input  logic                                      we_i,
  input  logic [cluster_periph_pkg::REG_W-1:0]      reg_i,
  input  logic [cluster_periph_pkg::DATA_W-1:0]     wdata_i,
  output logic [cluster_periph_pkg::DATA_W-1:0]     rdata_o,
  input  logic                                      timer_evt_i,
  input  logic                                      dma_evt_i,
  input  logic                                      dma_irq_i,
  input  logic                                      mailbox_evt_i,
  input  logic [cluster_periph_pkg::NB_EXT_EVT-1:0] ext_evt_i,
  output logic [NB_CORES-1:0]                       irq_req_o
);
  import cluster_periph_pkg::*;

  logic [NB_EVENTS-1:0] evt_lines;
  logic [NB_EVENTS-1:0] mask_q [NB_CORES];
  logic [NB_EVENTS-1:0] buf_q  [NB_CORES];
  logic [REG_W-1:0]     core_idx;
  logic [REG_W-1:0]     offset;
  logic [DATA_W-1:0]    rdata_d;

  // timer, dma event, dma irq, mailbox, then external lines
  assign evt_lines = {ext_evt_i, mailbox_evt_i, dma_irq_i, dma_evt_i, timer_evt_i};

  assign core_idx = reg_i / EU_STRIDE;
  assign offset   = reg_i % EU_STRIDE;

  // ********************
  // per-core mask and sticky buffer
  for (genvar c = 0; c < NB_CORES; c++) begin : gen_core
    logic                 hit;
    logic [NB_EVENTS-1:0] clr;

    assign hit = sel_i && we_i && (core_idx == REG_W'(c));
    assign clr = (hit && offset == EU_CLEAR) ? wdata_i[NB_EVENTS-1:0] : '0;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        mask_q[c] <= '0;
        buf_q[c]  <= '0;
      end else begin
        if (hit && offset == EU_MASK) begin
          mask_q[c] <= wdata_i[NB_EVENTS-1:0];
        end
        // an incoming event beats a clear on the same bit
        buf_q[c] <= (buf_q[c] & ~clr) | evt_lines;
      end
    end

    assign irq_req_o[c] = |(buf_q[c] & mask_q[c]);
  end

  // cores past NB_CORES read 0
  always_comb begin
    rdata_d = '0;
    for (int c = 0; c < NB_CORES; c++) begin
      if (core_idx == REG_W'(c)) begin
        if (offset == EU_MASK) rdata_d = DATA_W'(mask_q[c]);
        if (offset == EU_BUFFER) rdata_d = DATA_W'(buf_q[c]);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_i && !we_i) begin
      rdata_o <= rdata_d;
    end
  end

endmodule

// ==== cluster_peripherals.sv ====
`timescale 1ns/1ps

module cluster_peripherals #(
  parameter int                                 NB_CORES  = 4,
  parameter int                                 ID_W      = NB_CORES + 1,
  parameter logic [cluster_periph_pkg::DATA_W-1:0] BOOT_ADDR = 32'h1C00_0000
) (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,
  // peripheral bus slave port
  input  logic                                          periph_req_i,
  input  logic [31:0]                                   periph_add_i,
  input  logic                                          periph_wen_i,
  input  logic [cluster_periph_pkg::DATA_W-1:0]         periph_wdata_i,
  input  logic [ID_W-1:0]                               periph_id_i,
  output logic                                          periph_gnt_o,
  output logic                                          periph_r_valid_o,
  output logic                                          periph_r_opc_o,
  output logic [cluster_periph_pkg::DATA_W-1:0]         periph_r_rdata_o,
  output logic [ID_W-1:0]                               periph_r_id_o,
  // event sources
  input  logic                                          dma_evt_i,
  input  logic                                          dma_irq_i,
  input  logic                                          mailbox_evt_i,
  input  logic [cluster_periph_pkg::NB_EXT_EVT-1:0]     ext_evt_i,
  // core side
  output logic [NB_CORES-1:0]                           fetch_enable_o,
  output logic [NB_CORES-1:0][cluster_periph_pkg::DATA_W-1:0] boot_addr_o,
  output logic                                          eoc_o,
  output logic                                          busy_o,
  output logic [NB_CORES-1:0]                           irq_req_o
);
  import cluster_periph_pkg::*;

  logic              ctrl_sel, ctrl_we;
  logic [REG_W-1:0]  ctrl_reg;
  logic [DATA_W-1:0] ctrl_wdata, ctrl_rdata;
  logic              tmr_sel, tmr_we;
  logic [REG_W-1:0]  tmr_reg;
  logic [DATA_W-1:0] tmr_wdata, tmr_rdata;
  logic              eu_sel, eu_we;
  logic [REG_W-1:0]  eu_reg;
  logic [DATA_W-1:0] eu_wdata, eu_rdata;
  logic              timer_evt;

  // ********************
  // slave port decode
  periph_demux #(.ID_W(ID_W)) i_demux (
    .clk_i, .arst_n_i,
    .req_i(periph_req_i), .add_i(periph_add_i), .wen_i(periph_wen_i),
    .wdata_i(periph_wdata_i), .id_i(periph_id_i),
    .gnt_o(periph_gnt_o), .r_valid_o(periph_r_valid_o), .r_opc_o(periph_r_opc_o),
    .r_rdata_o(periph_r_rdata_o), .r_id_o(periph_r_id_o),
    .ctrl_sel_o(ctrl_sel), .ctrl_we_o(ctrl_we), .ctrl_reg_o(ctrl_reg),
    .ctrl_wdata_o(ctrl_wdata), .ctrl_rdata_i(ctrl_rdata),
    .tmr_sel_o(tmr_sel), .tmr_we_o(tmr_we), .tmr_reg_o(tmr_reg),
    .tmr_wdata_o(tmr_wdata), .tmr_rdata_i(tmr_rdata),
    .eu_sel_o(eu_sel), .eu_we_o(eu_we), .eu_reg_o(eu_reg),
    .eu_wdata_o(eu_wdata), .eu_rdata_i(eu_rdata)
  );

  // ********************
  // register units
  cluster_ctrl_unit #(.NB_CORES(NB_CORES), .BOOT_ADDR(BOOT_ADDR)) i_ctrl (
    .clk_i, .arst_n_i,
    .sel_i(ctrl_sel), .we_i(ctrl_we), .reg_i(ctrl_reg), .wdata_i(ctrl_wdata),
    .rdata_o(ctrl_rdata), .eoc_o, .fetch_enable_o, .boot_addr_o
  );

  cluster_timer i_timer (
    .clk_i, .arst_n_i,
    .sel_i(tmr_sel), .we_i(tmr_we), .reg_i(tmr_reg), .wdata_i(tmr_wdata),
    .rdata_o(tmr_rdata), .evt_o(timer_evt), .busy_o
  );

  event_unit #(.NB_CORES(NB_CORES)) i_event (
    .clk_i, .arst_n_i,
    .sel_i(eu_sel), .we_i(eu_we), .reg_i(eu_reg), .wdata_i(eu_wdata),
    .rdata_o(eu_rdata), .timer_evt_i(timer_evt), .dma_evt_i, .dma_irq_i,
    .mailbox_evt_i, .ext_evt_i, .irq_req_o
  );

endmodule

// ==== cluster_peripherals_props.sv ====
`timescale 1ns/1ps

module cluster_peripherals_props #(
  parameter int NB_CORES = 4
) (
  input logic                clk_i,
  input logic                arst_n_i,
  input logic                periph_req_i,
  input logic                periph_gnt_o,
  input logic                periph_r_valid_o,
  input logic                eoc_o,
  input logic [NB_CORES-1:0] irq_req_o
);

  // every slot grants in the cycle of the request
  gnt_is_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    periph_gnt_o == periph_req_i) else $error("gnt differs from req");

  // response exactly one cycle after a grant, and never without one
  rsp_after_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    periph_gnt_o |=> periph_r_valid_o) else $error("no response after grant");
  no_rsp_alone: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !periph_gnt_o |=> !periph_r_valid_o) else $error("response without grant");

  rst_quiet: assert property (@(posedge clk_i)
    !arst_n_i |-> (!eoc_o && irq_req_o == '0)) else $error("outputs active in reset");

endmodule

bind cluster_peripherals cluster_peripherals_props #(.NB_CORES(NB_CORES)) props (.*);

// ==== tb_cluster_peripherals.sv ====
`timescale 1ns/1ps

module tb_cluster_peripherals;
  localparam int NB = 4;
  localparam logic [31:0] BOOT = 32'h1C00_0000;
  localparam logic [31:0] ERR = 32'hBADC_AB7E;
  localparam int LIMIT = 20000;

  logic clk_i = 1'b0, arst_n_i = 1'b0;
  logic req = 1'b0, wen = 1'b0, dma_evt = 1'b0, dma_irq = 1'b0, mbx_evt = 1'b0;
  logic [31:0] add = '0, wdata = '0;
  logic [4:0] id = '0;
  logic [3:0] ext_evt = '0;
  logic gnt, r_valid, r_opc, eoc, busy;
  logic [31:0] r_rdata;
  logic [4:0] r_id;
  logic [NB-1:0] fetch_en, irq;
  logic [NB-1:0][31:0] boot_addr;

  // model state
  logic eoc_m = 1'b0, tmr_en_m = 1'b0, model_on = 1'b1, gnt_prev = 1'b0;
  logic [NB-1:0] fe_m = '0;
  logic [31:0] boot_m [NB];
  logic [7:0] mask_m [NB], buf_m [NB];
  logic pend_v = 1'b0;
  logic [3:0] pend_slv;
  logic [7:0] pend_idx;
  logic [31:0] pend_d, rng = 32'd46;
  logic [37:0] exp_q [$];
  int mism = 0, other = 0, cycles = 0;

  cluster_peripherals dut (
    .clk_i, .arst_n_i, .periph_req_i(req), .periph_add_i(add), .periph_wen_i(wen),
    .periph_wdata_i(wdata), .periph_id_i(id), .periph_gnt_o(gnt),
    .periph_r_valid_o(r_valid), .periph_r_opc_o(r_opc), .periph_r_rdata_o(r_rdata),
    .periph_r_id_o(r_id), .dma_evt_i(dma_evt), .dma_irq_i(dma_irq),
    .mailbox_evt_i(mbx_evt), .ext_evt_i(ext_evt), .fetch_enable_o(fetch_en),
    .boot_addr_o(boot_addr), .eoc_o(eoc), .busy_o(busy), .irq_req_o(irq)
  );

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] lcg();
    rng = rng * 32'd1103515245 + 32'd12345;
    return {1'b0, rng[31:1]};
  endfunction

  function automatic logic [31:0] model_read(input logic [3:0] slv, input logic [7:0] idx);
    int core;
    core = idx / 4;
    if (slv == 0 && idx == 0) return {31'd0, eoc_m};
    if (slv == 0 && idx == 1) return {28'd0, fe_m};
    if (slv == 0 && idx >= 16 && idx < 16 + NB) return boot_m[idx-16];
    if (slv == 2 && core < NB && idx % 4 == 0) return {24'd0, mask_m[core]};
    if (slv == 2 && core < NB && idx % 4 == 1) return {24'd0, buf_m[core]};
    return '0;
  endfunction

  // drive one access for the current cycle from the rising edge
  task automatic issue(input logic rd, input logic [3:0] slv, input logic [7:0] idx,
                       input logic [31:0] wd);
    logic [31:0] exp_d;
    exp_d = (slv > 2) ? ERR : (rd ? model_read(slv, idx) : 32'd0);
    req <= 1'b1;
    wen <= rd;
    add <= {18'(lcg()), slv, idx, 2'b00};
    wdata <= wd;
    id <= id + 5'd1;
    exp_q.push_back({slv > 2, id + 5'd1, exp_d});
    if (!rd && slv <= 2) begin
      pend_v = 1'b1;
      pend_slv = slv;
      pend_idx = idx;
      pend_d = wd;
    end
  endtask

  task automatic idle(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk_i);
      req <= 1'b0;
    end
  endtask

  // ********************
  // check responses and outputs before the model moves to the coming edge
  always @(negedge clk_i) begin
    logic [37:0] e;
    int core;
    if (arst_n_i) begin
      if (r_valid) begin
        if (exp_q.size() == 0) begin
          $display("response arrived with no access outstanding at %0t", $time);
          other++;
        end else begin
          e = exp_q.pop_front();
          if (r_id != e[36:32] || r_rdata != e[31:0] || r_opc != e[37]) begin
            $display("MISMATCH %0t: id %0d data %h opc %b, expected id %0d data %h opc %b",
                     $time, r_id, r_rdata, r_opc, e[36:32], e[31:0], e[37]);
            mism++;
          end
        end
      end else if (gnt_prev) begin
        $display("granted access got no response at %0t", $time);
        other++;
      end
      gnt_prev = gnt;
      if (eoc != eoc_m || fetch_en != fe_m || busy != tmr_en_m) begin
        $display("MISMATCH %0t: eoc %b fetch %h busy %b", $time, eoc, fetch_en, busy);
        mism++;
      end
      for (int c = 0; c < NB; c++) begin
        if (boot_addr[c] != boot_m[c]) begin
          $display("MISMATCH %0t: boot_addr[%0d] %h", $time, c, boot_addr[c]);
          mism++;
        end
        if (model_on && irq[c] != |(buf_m[c] & mask_m[c])) begin
          $display("MISMATCH %0t: irq_req[%0d] %b", $time, c, irq[c]);
          mism++;
        end
      end
      if (pend_v) begin
        core = pend_idx / 4;
        if (pend_slv == 0 && pend_idx == 0) eoc_m = pend_d[0];
        if (pend_slv == 0 && pend_idx == 1) fe_m = pend_d[NB-1:0];
        if (pend_slv == 0 && pend_idx >= 16 && pend_idx < 16 + NB) boot_m[pend_idx-16] = pend_d;
        if (pend_slv == 1 && pend_idx == 0) tmr_en_m = pend_d[0];
        if (pend_slv == 2 && core < NB && pend_idx % 4 == 0) mask_m[core] = pend_d[7:0];
        if (pend_slv == 2 && core < NB && pend_idx % 4 == 2) buf_m[core] &= ~pend_d[7:0];
        pend_v = 1'b0;
      end
      // set wins over a clear at the same edge
      for (int c = 0; c < NB; c++) begin
        buf_m[c] |= {ext_evt, mbx_evt, dma_irq, dma_evt, 1'b0};
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("run did not finish within %0d cycles", LIMIT);
      $display("sim failed");
      $finish;
    end
  end

  initial begin
    int c, n;
    logic [31:0] r, cmp;
    for (int i = 0; i < NB; i++) begin
      boot_m[i] = BOOT;
      mask_m[i] = '0;
      buf_m[i] = '0;
    end
    repeat (3) @(posedge clk_i);
    arst_n_i <= 1'b1;

    // ********************
    // reset values and boot reads
    for (int i = 0; i < NB; i++) begin
      @(posedge clk_i);
      issue(1'b1, 4'd0, 8'(16 + i), '0);
    end
    idle(2);

    // control registers with some accesses back to back
    for (int i = 0; i < 60; i++) begin
      @(posedge clk_i);
      r = lcg();
      case (r[3:1])
        0: c = 0;
        1: c = 1;
        2: c = 5;
        default: c = 16 + r[5:4];
      endcase
      issue(r[0], 4'd0, 8'(c), lcg());
      if (r[7:6] == 0) idle(1);
    end

    // unmapped slots aimed at indices that exist in the mapped units
    for (int i = 0; i < 20; i++) begin
      @(posedge clk_i);
      r = lcg();
      issue(r[0], 4'(3 + r[8:1] % 13), 8'(r[16:9] % 20), lcg());
    end
    idle(2);

    // ********************
    // event unit with random masks and pulses
    for (int i = 0; i < 80; i++) begin
      @(posedge clk_i);
      r = lcg();
      dma_evt <= (r[3:0] == 0);
      dma_irq <= (r[7:4] == 0);
      mbx_evt <= (r[11:8] == 0);
      ext_evt <= r[15:12] & r[19:16] & r[23:20];
      c = r[26:24] % 5;
      case (r[29:27])
        0: issue(1'b0, 4'd2, 8'(c * 4), lcg());
        1: issue(1'b0, 4'd2, 8'(c * 4 + 2), lcg());
        2, 3: issue(1'b1, 4'd2, 8'(c * 4 + 1), '0);
        4: issue(1'b1, 4'd2, 8'(c * 4), '0);
        default: req <= 1'b0;
      endcase
    end
    @(posedge clk_i);
    dma_evt <= 1'b0;
    dma_irq <= 1'b0;
    mbx_evt <= 1'b0;
    ext_evt <= '0;
    req <= 1'b0;
    idle(2);

    // ********************
    // timer period and event for three compare values
    for (int t = 0; t < 3; t++) begin
      cmp = 2 + lcg() % 6;
      model_on = 1'b0;
      @(posedge clk_i);
      issue(1'b0, 4'd1, 8'd0, 32'd2);
      @(posedge clk_i);
      issue(1'b0, 4'd1, 8'd2, cmp);
      @(posedge clk_i);
      issue(1'b0, 4'd2, 8'd0, 32'h01);
      @(posedge clk_i);
      issue(1'b0, 4'd2, 8'd2, 32'hFF);
      @(posedge clk_i);
      issue(1'b0, 4'd1, 8'd0, 32'd1);
      idle(1);
      n = 0;
      while (!irq[0] && n <= cmp + 3) begin
        @(negedge clk_i);
        n++;
      end
      if (n > cmp + 3) begin
        $display("timer event not seen within %0d cycles", cmp + 3);
        other++;
      end
      n = 0;
      while (!dut.i_timer.evt_o && n < 20) begin
        @(negedge clk_i);
        n++;
      end
      n = 0;
      do begin
        @(negedge clk_i);
        n++;
      end while (!dut.i_timer.evt_o && n < 20);
      if (n != cmp + 1) begin
        $display("MISMATCH %0t: timer period %0d, expected %0d", $time, n, cmp + 1);
        mism++;
      end
      // stop and clear the timer so the buffers stay quiet
      @(posedge clk_i);
      issue(1'b0, 4'd1, 8'd0, 32'd2);
      for (int k = 0; k < NB; k++) begin
        @(posedge clk_i);
        issue(1'b0, 4'd2, 8'(k * 4 + 2), 32'hFF);
      end
      idle(1);
      model_on = 1'b1;
      idle(cmp + 5);
      @(posedge clk_i);
      issue(1'b1, 4'd2, 8'd1, '0);
      idle(2);
    end

    idle(3);
    if (exp_q.size() != 0) begin
      $display("%0d responses never arrived", exp_q.size());
      other++;
    end
    $display("errors: %0d mismatches, %0d other failures", mism, other);
    if (mism + other == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
cluster_periph_pkg.sv
periph_demux.sv
cluster_ctrl_unit.sv
cluster_timer.sv
event_unit.sv
cluster_peripherals.sv
cluster_peripherals_props.sv
tb_cluster_peripherals.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wall -Wno-fatal \
  --top-module tb_cluster_peripherals \
  -f files.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

echo "$out" | grep -q "^sim passed$"
